// File: sources.f
+incdir+src
src/memory_controller_interface.sv
src/core_port_pkg.sv
src/block_memory.sv
src/memory_arbiter.sv
src/instruction_cache.sv
src/data_cache.sv
src/memory_subsystem.sv
tb/memory_subsystem_assertions.sv
tb/memory_subsystem_tb.sv

// File: tb/memory_subsystem_tb.sv
`timescale 1ns/100ps

module memory_subsystem_tb
    import memory_controller_interface::*, core_port_pkg::*;
();

    localparam int N_WORDS    = 64;     // Preloaded region from address 0
    localparam int N_RANDOM   = 200;    // Paired fetch and data accesses
    localparam int OP_CYCLES  = 48;     // Worst single access under contention
    localparam int MAX_CYCLES = (24 + N_WORDS + N_RANDOM) * OP_CYCLES;

    logic       i_clk;
    logic       rst;
    core_req_t  ireq;
    core_rsp_t  irsp;
    core_req_t  dreq;
    core_rsp_t  drsp;
    core_word_t shadow [1024];          // Expected memory contents by word address
    int         seed   = 32'h3e95;
    int         cycles = 0;
    logic [31:0] r;
    core_word_t  w;
    mci_addr_t   ia;
    mci_addr_t   da;

    memory_subsystem u_dut (
        .i_clk (i_clk),
        .rst   (rst),
        .ireq  (ireq),
        .irsp  (irsp),
        .dreq  (dreq),
        .drsp  (drsp)
    );

    bind memory_subsystem memory_subsystem_assertions u_assert (.*);

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped on first error");
    endtask

    task automatic check_word(input string name, input mci_addr_t addr,
                              input core_word_t got, input core_word_t exp);
        assert (got === exp)
        else fail_run($sformatf("FAIL %s at %h got %h expected %h", name, addr, got, exp));
    endtask

    // Request held from one falling edge until the edge that samples ready
    task automatic data_access(input logic we, input mci_addr_t addr, input core_word_t wdata);
        @(negedge i_clk);                   // Leaves valid low for a cycle in between
        dreq = '{valid: 1'b1, we: we, addr: addr, wdata: wdata};
        do begin
            @(negedge i_clk);
        end while (!drsp.ready);
        if (we) shadow[addr[11:2]] = wdata;
        else check_word("drsp.rdata", addr, drsp.rdata, shadow[addr[11:2]]);
        @(negedge i_clk);                   // Ready sampled with valid still high
        dreq.valid = 1'b0;
    endtask

    task automatic fetch(input mci_addr_t addr);
        @(negedge i_clk);
        ireq = '{valid: 1'b1, we: 1'b0, addr: addr, wdata: '0};
        do begin
            @(negedge i_clk);
        end while (!irsp.ready);
        check_word("irsp.rdata", addr, irsp.rdata, shadow[addr[11:2]]);
        @(negedge i_clk);
        ireq.valid = 1'b0;
    endtask

    // Assertion watch and cycle limit
    always @(negedge i_clk) begin
        cycles++;
        if (u_dut.u_assert.err_count != 0) fail_run("a handshake assertion failed");
        else if (cycles > MAX_CYCLES) fail_run("timeout before all requests completed");
    end

    initial begin
        rst  = 1'b1;
        ireq = '0;
        dreq = '0;
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        rst = 1'b0;
        repeat (5) @(negedge i_clk);        // Idle, nothing may answer

        data_access(1'b1, 32'h200, 32'hcafe_0001);  // Store miss allocates
        data_access(1'b0, 32'h200, '0);
        data_access(1'b1, 32'h204, 32'hcafe_0002);  // Neighbor in the same block
        data_access(1'b0, 32'h204, '0);
        data_access(1'b0, 32'h200, '0);
        data_access(1'b1, 32'h200, 32'hbeef_0003);  // Store hit
        data_access(1'b0, 32'h200, '0);
        fetch(32'h200);                     // First fetch sees the written-through word

        for (int i = 0; i < N_WORDS; i++) data_access(1'b1, mci_addr_t'(i * 4), $random(seed));

        // Fetches read words 0..31 only, stores touch words 32..63
        repeat (N_RANDOM) begin
            r  = $random(seed);
            w  = $random(seed);
            ia = mci_addr_t'({r[4:0], 2'b00});
            da = r[5] ? mci_addr_t'({1'b1, r[10:6], 2'b00}) : mci_addr_t'({r[11:6], 2'b00});
            fork
                fetch(ia);
                data_access(r[5], da, w);
            join
        end

        // Line 0 under three tags
        data_access(1'b1, 32'h400, 32'h1111_4444);
        data_access(1'b1, 32'h800, 32'h2222_8888);
        data_access(1'b0, 32'h400, '0);
        data_access(1'b0, 32'h800, '0);
        fetch(32'h400);
        fetch(32'h800);
        fetch(32'h400);

        @(negedge i_clk);
        if (u_dut.u_assert.err_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            fail_run("handshake assertion failures were recorded");
        end
    end

endmodule

// File: tb/memory_subsystem_assertions.sv
`timescale 1ns/100ps

module memory_subsystem_assertions
    import memory_controller_interface::*, core_port_pkg::*;
#(
    parameter int CORE_BOUND = 48,  // Store miss queued behind a fill
    parameter int MEM_BOUND  = 12   // Grant to memory ready at default latency
) (
    input logic          i_clk,
    input logic          rst,
    input core_req_t     ireq,
    input core_rsp_t     irsp,
    input core_req_t     dreq,
    input core_rsp_t     drsp,
    input mci_request_t  ic_mem_req,
    input mci_response_t ic_mem_res,
    input mci_request_t  dc_mem_req,
    input mci_response_t dc_mem_res,
    input mci_request_t  mem_req,
    input mci_response_t mem_res
);
    int unsigned err_count = 0;     // Failures so far, watched from the testbench

    task automatic record_failure(input string what);
        $error("%s", what);
        err_count++;
    endtask

    // Ready only answers a live request, on every port
    a_ready_valid: assert property (@(posedge i_clk) disable iff (rst)
        (!irsp.ready || ireq.valid) && (!drsp.ready || dreq.valid) &&
        (!ic_mem_res.ready || ic_mem_req.valid) && (!dc_mem_res.ready || dc_mem_req.valid) &&
        (!mem_res.ready || mem_req.valid))
        else record_failure("ready raised without valid");

    // Memory side stays quiet while the core side is idle
    a_quiet: assert property (@(posedge i_clk) disable iff (rst)
        (ireq.valid || !ic_mem_req.valid) && (dreq.valid || !dc_mem_req.valid) &&
        (ic_mem_req.valid || dc_mem_req.valid || !mem_req.valid))
        else record_failure("memory request without a core request");

    a_one_owner: assert property (@(posedge i_clk) disable iff (rst)
        !(ic_mem_res.ready && dc_mem_res.ready))
        else record_failure("arbiter answered both caches in one cycle");

    // A waiting request keeps every field
    a_ireq_hold: assert property (@(posedge i_clk) disable iff (rst)
        ireq.valid && !irsp.ready |=> $stable(ireq))
        else record_failure("instruction request changed before ready");
    a_dreq_hold: assert property (@(posedge i_clk) disable iff (rst)
        dreq.valid && !drsp.ready |=> $stable(dreq))
        else record_failure("data request changed before ready");
    a_ic_mem_hold: assert property (@(posedge i_clk) disable iff (rst)
        ic_mem_req.valid && !ic_mem_res.ready |=> $stable(ic_mem_req))
        else record_failure("instruction cache block request changed before ready");
    a_dc_mem_hold: assert property (@(posedge i_clk) disable iff (rst)
        dc_mem_req.valid && !dc_mem_res.ready |=> $stable(dc_mem_req))
        else record_failure("data cache block request changed before ready");
    a_mem_hold: assert property (@(posedge i_clk) disable iff (rst)
        mem_req.valid && !mem_res.ready |=> $stable(mem_req))
        else record_failure("granted memory request changed before ready");

    // Bounded completion, also shows neither cache starves
    a_ifetch_done: assert property (@(posedge i_clk) disable iff (rst)
        $rose(ireq.valid) |-> ##[1:CORE_BOUND] irsp.ready)
        else record_failure("instruction fetch got no ready in time");
    a_data_done: assert property (@(posedge i_clk) disable iff (rst)
        $rose(dreq.valid) |-> ##[1:CORE_BOUND] drsp.ready)
        else record_failure("data access got no ready in time");
    a_mem_done: assert property (@(posedge i_clk) disable iff (rst)
        $rose(mem_req.valid) |-> ##[1:MEM_BOUND] mem_res.ready)
        else record_failure("main memory got no ready in time");

endmodule

// File: src/memory_subsystem.sv
`timescale 1ns/100ps

module memory_subsystem
    import memory_controller_interface::*, core_port_pkg::*;
(
    input  logic      i_clk,
    input  logic      rst,
    input  core_req_t ireq,     // Instruction fetch
    output core_rsp_t irsp,
    input  core_req_t dreq,     // Loads and stores
    output core_rsp_t drsp
);
    mci_request_t  ic_mem_req;  // Cache to arbiter
    mci_response_t ic_mem_res;
    mci_request_t  dc_mem_req;
    mci_response_t dc_mem_res;
    mci_request_t  mem_req;     // Arbiter to memory
    mci_response_t mem_res;

    instruction_cache u_icache (
        .i_clk    (i_clk),
        .rst      (rst),
        .core_req (ireq),
        .core_rsp (irsp),
        .mem_req  (ic_mem_req),
        .mem_res  (ic_mem_res)
    );

    data_cache u_dcache (
        .i_clk    (i_clk),
        .rst      (rst),
        .core_req (dreq),
        .core_rsp (drsp),
        .mem_req  (dc_mem_req),
        .mem_res  (dc_mem_res)
    );

    memory_arbiter u_arbiter (
        .i_clk    (i_clk),
        .rst      (rst),
        .ireq_mem (ic_mem_req),
        .ires_mem (ic_mem_res),
        .dreq_mem (dc_mem_req),
        .dres_mem (dc_mem_res),
        .mem_req  (mem_req),
        .mem_res  (mem_res)
    );

    block_memory u_memory (
        .i_clk   (i_clk),
        .rst     (rst),
        .mem_req (mem_req),
        .mem_res (mem_res)
    );

endmodule

// File: src/data_cache.sv
`timescale 1ns/100ps
`include "mci_macros.svh"

module data_cache
    import memory_controller_interface::*, core_port_pkg::*;
#(
    parameter int LINES = 4     // Power of two, at least 2
) (
    input  logic          i_clk,
    input  logic          rst,
    input  core_req_t     core_req,
    output core_rsp_t     core_rsp,
    output mci_request_t  mem_req,
    input  mci_response_t mem_res
);
    localparam int BLK_LSB  = $clog2(`MCI_DATA_LENGTH / 8);
    localparam int WORD_LSB = $clog2(`MCI_WORD_LENGTH / 8);
    localparam int IDX_W    = $clog2(LINES);

    typedef enum logic [1:0] {
        DC_IDLE,
        DC_FILL,    // Block read in flight
        DC_GAP,     // Valid low for a cycle between fill and write
        DC_WRITE    // Write-through of the merged block
    } dc_state_e;

    cache_line_t                            lines [LINES];
    dc_state_e                              state;
    cache_tag_t                             tag;
    logic [IDX_W-1:0]                       idx;
    logic [$clog2(`MCI_WORDS_IN_BLOCK)-1:0] wsel;
    logic                                   hit;
    logic                                   accept;
    logic                                   mreq_valid;
    logic                                   mreq_rw;
    mci_block_u                             wblk;       // Block sent on write
    mci_block_u                             hit_merge;
    mci_block_u                             fill_merge;
    logic                                   rsp_ready;
    core_word_t                             rsp_data;

    assign tag    = core_req.addr[`MCI_ADDR_LENGTH-1:BLK_LSB];
    assign idx    = core_req.addr[BLK_LSB +: IDX_W];
    assign wsel   = core_req.addr[BLK_LSB-1:WORD_LSB];
    assign hit    = lines[idx].valid && (lines[idx].tag == tag);
    assign accept = core_req.valid && !rsp_ready && (state == DC_IDLE);

    // Store word merged into the cached or the returned block
    always_comb begin
        hit_merge              = lines[idx].data;
        hit_merge.words[wsel]  = core_req.wdata;
        fill_merge             = mem_res.data;
        fill_merge.words[wsel] = core_req.wdata;
    end

    always_ff @(posedge i_clk) begin
        if (rst) begin
            state      <= DC_IDLE;
            mreq_valid <= 1'b0;
            mreq_rw    <= 1'b0;
            rsp_ready  <= 1'b0;
            wblk       <= '0;
            for (int i = 0; i < LINES; i++) lines[i].valid <= 1'b0;
        end else begin
            rsp_ready <= 1'b0;
            unique case (state)
                DC_IDLE: if (accept) begin
                    if (hit && !core_req.we) begin
                        rsp_ready <= 1'b1;                      // Load hit
                        rsp_data  <= lines[idx].data.words[wsel];
                    end else if (hit) begin
                        lines[idx].data <= hit_merge;           // Store hit, write through now
                        wblk            <= hit_merge;
                        mreq_valid      <= 1'b1;
                        mreq_rw         <= 1'b1;
                        state           <= DC_WRITE;
                    end else begin
                        mreq_valid <= 1'b1;                     // Miss, allocate for both kinds
                        mreq_rw    <= 1'b0;
                        state      <= DC_FILL;
                    end
                end
                DC_FILL: if (mem_res.ready) begin
                    mreq_valid <= 1'b0;
                    if (core_req.we) begin
                        lines[idx] <= '{valid: 1'b1, tag: tag, data: fill_merge};
                        wblk       <= fill_merge;
                        state      <= DC_GAP;
                    end else begin
                        lines[idx] <= '{valid: 1'b1, tag: tag, data: mem_res.data};
                        rsp_ready  <= 1'b1;
                        rsp_data   <= mem_res.data.words[wsel];
                        state      <= DC_IDLE;
                    end
                end
                DC_GAP: begin
                    mreq_valid <= 1'b1;
                    mreq_rw    <= 1'b1;
                    state      <= DC_WRITE;
                end
                DC_WRITE: if (mem_res.ready) begin
                    mreq_valid <= 1'b0;
                    rsp_ready  <= 1'b1;     // Store done once memory has it
                    rsp_data   <= core_req.wdata;
                    state      <= DC_IDLE;
                end
                default: state <= DC_IDLE;
            endcase
        end
    end

    assign mem_req  = '{valid: mreq_valid, rw: mreq_rw, addr: {tag, {BLK_LSB{1'b0}}}, data: wblk};
    assign core_rsp = '{ready: rsp_ready, rdata: rsp_data};

endmodule

// File: src/instruction_cache.sv
`timescale 1ns/100ps
`include "mci_macros.svh"

module instruction_cache
    import memory_controller_interface::*, core_port_pkg::*;
#(
    parameter int LINES = 4     // Power of two, at least 2
) (
    input  logic          i_clk,
    input  logic          rst,
    input  core_req_t     core_req,     // we and wdata unused, fetch only
    output core_rsp_t     core_rsp,
    output mci_request_t  mem_req,
    input  mci_response_t mem_res
);
    localparam int BLK_LSB  = $clog2(`MCI_DATA_LENGTH / 8);
    localparam int WORD_LSB = $clog2(`MCI_WORD_LENGTH / 8);
    localparam int IDX_W    = $clog2(LINES);

    typedef enum logic {IC_IDLE, IC_FILL} ic_state_e;

    cache_line_t                            lines [LINES];
    ic_state_e                              state;
    cache_tag_t                             tag;
    logic [IDX_W-1:0]                       idx;
    logic [$clog2(`MCI_WORDS_IN_BLOCK)-1:0] wsel;       // Word within the block
    logic                                   hit;
    logic                                   accept;
    logic                                   fill_valid;
    logic                                   rsp_ready;
    core_word_t                             rsp_data;

    // Address split, the core holds addr until ready
    assign tag    = core_req.addr[`MCI_ADDR_LENGTH-1:BLK_LSB];
    assign idx    = core_req.addr[BLK_LSB +: IDX_W];
    assign wsel   = core_req.addr[BLK_LSB-1:WORD_LSB];
    assign hit    = lines[idx].valid && (lines[idx].tag == tag);
    assign accept = core_req.valid && !rsp_ready && (state == IC_IDLE);  // Skip the ready cycle

    always_ff @(posedge i_clk) begin
        if (rst) begin
            state      <= IC_IDLE;
            fill_valid <= 1'b0;
            rsp_ready  <= 1'b0;
            for (int i = 0; i < LINES; i++) lines[i].valid <= 1'b0;
        end else begin
            rsp_ready <= 1'b0;
            unique case (state)
                IC_IDLE: if (accept) begin
                    if (hit) begin
                        rsp_ready <= 1'b1;                          // Hit answers next cycle
                        rsp_data  <= lines[idx].data.words[wsel];
                    end else begin
                        fill_valid <= 1'b1;                         // Block read
                        state      <= IC_FILL;
                    end
                end
                IC_FILL: if (mem_res.ready) begin
                    fill_valid <= 1'b0;
                    lines[idx] <= '{valid: 1'b1, tag: tag, data: mem_res.data};
                    rsp_ready  <= 1'b1;
                    rsp_data   <= mem_res.data.words[wsel];         // Critical word from bus
                    state      <= IC_IDLE;
                end
                default: state <= IC_IDLE;
            endcase
        end
    end

    assign mem_req  = '{valid: fill_valid, rw: 1'b0, addr: {tag, {BLK_LSB{1'b0}}}, data: '0};
    assign core_rsp = '{ready: rsp_ready, rdata: rsp_data};

endmodule

// File: src/memory_arbiter.sv
`timescale 1ns/100ps

module memory_arbiter
    import memory_controller_interface::*;
(
    input  logic          i_clk,
    input  logic          rst,
    input  mci_request_t  ireq_mem,     // Instruction cache side
    output mci_response_t ires_mem,
    input  mci_request_t  dreq_mem,     // Data cache side
    output mci_response_t dres_mem,
    output mci_request_t  mem_req,      // Toward main memory
    input  mci_response_t mem_res
);
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_INSN,
        ARB_DATA
    } arb_state_e;

    arb_state_e state;
    logic       last_data;  // Data cache held the latest grant

    always_ff @(posedge i_clk) begin
        if (rst) begin
            state     <= ARB_IDLE;
            last_data <= 1'b0;
        end else begin
            unique case (state)
                ARB_IDLE: begin
                    // On a tie the side that lost last time wins
                    if (ireq_mem.valid && (!dreq_mem.valid || last_data)) begin
                        state     <= ARB_INSN;
                        last_data <= 1'b0;
                    end else if (dreq_mem.valid) begin
                        state     <= ARB_DATA;
                        last_data <= 1'b1;
                    end
                end
                ARB_INSN, ARB_DATA: begin
                    if (mem_res.ready) state <= ARB_IDLE;    // Release after the ready cycle
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Forward the granted request, steer ready back to its owner only
    always_comb begin
        mem_req        = '0;                    // No request while idle
        ires_mem       = mem_res;
        dres_mem       = mem_res;
        ires_mem.ready = 1'b0;
        dres_mem.ready = 1'b0;
        unique case (state)
            ARB_INSN: begin
                mem_req        = ireq_mem;
                ires_mem.ready = mem_res.ready;
            end
            ARB_DATA: begin
                mem_req        = dreq_mem;
                dres_mem.ready = mem_res.ready;
            end
            default: ;                          // Both requesters wait
        endcase
    end

endmodule

// File: src/block_memory.sv
`timescale 1ns/100ps
`include "mci_macros.svh"

module block_memory
    import memory_controller_interface::*;
#(
    parameter int MEM_DELAY = `MEM_DEFAULT_DELAY    // Cycles from request to ready, at least 1
) (
    input  logic          i_clk,
    input  logic          rst,
    input  mci_request_t  mem_req,
    output mci_response_t mem_res
);
    localparam int BLK_LSB = $clog2(`MCI_DATA_LENGTH / 8);  // Byte offset bits in a block
    localparam int IDX_W   = $clog2(`MEM_BLOCKS);
    localparam int CNT_W   = $clog2(MEM_DELAY + 1);

    mci_block_u       mem [`MEM_BLOCKS];
    logic [IDX_W-1:0] blk_idx;
    logic [CNT_W-1:0] count;        // Cycles left before ready
    logic             busy;
    logic             start;
    logic             ready_q;
    mci_block_u       rdata_q;

    assign blk_idx = mem_req.addr[BLK_LSB +: IDX_W];    // Upper bits wrap
    // New request only when idle and not in the ready cycle of the last one
    assign start   = mem_req.valid && !busy && !ready_q;

    always_ff @(posedge i_clk) begin
        if (rst) begin
            busy    <= 1'b0;
            count   <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b0;                        // Pulse for one cycle only
            if (busy) begin
                if (count == '0) begin
                    busy    <= 1'b0;
                    ready_q <= 1'b1;
                end else begin
                    count <= count - 1'b1;
                end
            end else if (start) begin
                busy  <= 1'b1;
                count <= CNT_W'(MEM_DELAY - 1);
            end
        end
    end

    // Storage path
    always_ff @(posedge i_clk) begin
        if (!rst && start && mem_req.rw) begin
            for (int i = 0; i < `MCI_WORDS_IN_BLOCK; i++) begin
                mem[blk_idx].words[i] <= mem_req.data.words[i];  // Commit on first edge
            end
        end
        if (busy && count == '0) rdata_q <= mem[blk_idx];       // Lands in the ready cycle
    end

    assign mem_res = '{ready: ready_q, data: rdata_q};

endmodule

// File: src/core_port_pkg.sv
package core_port_pkg;

`include "mci_macros.svh"

    import memory_controller_interface::*;

    typedef logic [`MCI_WORD_LENGTH-1:0] core_word_t;

    // Tag keeps the full block address so any line count works
    typedef logic [`MCI_ADDR_LENGTH-1:$clog2(`MCI_DATA_LENGTH / 8)] cache_tag_t;

    // Word request from the core, held until ready
    typedef struct packed {
        logic       valid;
        logic       we;     // Store when set
        mci_addr_t  addr;   // Byte address of the word
        core_word_t wdata;
    } core_req_t;

    typedef struct packed {
        logic       ready;  // One-cycle completion pulse
        core_word_t rdata;
    } core_rsp_t;

    // One cache line
    typedef struct packed {
        logic       valid;
        cache_tag_t tag;
        mci_block_u data;
    } cache_line_t;

endpackage

// File: src/memory_controller_interface.sv
package memory_controller_interface;

`include "mci_macros.svh"

    // Byte address seen by main memory, block aligned on the bus
    typedef logic [`MCI_ADDR_LENGTH-1:0] mci_addr_t;

    // One block, either as a flat bus or as its words
    typedef union packed {
        logic [`MCI_DATA_LENGTH-1:0]                             bits;
        logic [`MCI_WORDS_IN_BLOCK-1:0][`MCI_WORD_LENGTH-1:0]    words; // words[0] at lowest address
    } mci_block_u;

    // Block request, held stable until ready
    typedef struct packed {
        logic       valid;
        logic       rw;     // 1 = write, 0 = read
        mci_addr_t  addr;
        mci_block_u data;   // Write payload
    } mci_request_t;

    // Block response, ready is a one-cycle pulse
    typedef struct packed {
        logic       ready;
        mci_block_u data;   // Read data, valid with ready
    } mci_response_t;

endpackage

// File: src/mci_macros.svh
`ifndef MCI_MACROS_SVH
`define MCI_MACROS_SVH

// Word and block geometry of the memory port
`define MCI_WORD_LENGTH    32   // Bits per word
`define MCI_DATA_LENGTH    128  // Bits per block, one memory transfer
`define MCI_WORDS_IN_BLOCK 4    // Words carried by one block
`define MCI_ADDR_LENGTH    32   // Byte address width

// Behavioral main memory
`define MEM_BLOCKS         256  // Depth in blocks, 4 KiB total
`define MEM_DEFAULT_DELAY  5    // Read/write latency in clock cycles

`endif
